/* verilog.f */
+incdir+include
logic/cmo_pkg.sv
logic/cmo_walker.sv
logic/cmo_flush_fifo.sv
logic/cmo_ctrl.sv
logic/cmo_top.sv
tests/tb_cmo.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run tb_cmo with Verilator, then search the log for the fail message
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_cmo -o tb_cmo \
    && ./obj_dir/tb_cmo | tee sim.log \
    || echo "Errors found" | tee -a sim.log
grep -q "Errors found" sim.log && echo "FAIL" && exit 1
echo "PASS"
exit 0

/* tests/tb_cmo.sv */
// Table-driven testbench with a registered directory model and a flush-controller model
// Random directory tags keep the top bit clear, so table lines with it set are planted or miss
`include "cmo_defines.svh"

module tb_cmo import cmo_pkg::*; ();

    localparam int ROWS        = 11;
    localparam int TIMEOUT_CYC = ROWS * 200;
    localparam int RAND_TAG_W  = `CMO_TAG_W - 1;

    logic       clk_i = 1'b0;
    logic       rst_ni;
    logic       req_valid_i;
    cmo_op_e    req_op_i;
    cmo_addr_t  req_addr_i;
    logic       req_ready_o;
    logic       req_wait_o;
    logic       wbuf_empty_i;
    logic       mshr_empty_i;
    logic       rtab_empty_i;
    logic       ctrl_empty_i;
    logic       flush_empty_i = 1'b1;
    logic       wbuf_flush_all_o;
    logic       dir_check_nline_o;
    cmo_set_t   dir_check_nline_set_o;
    cmo_tag_t   dir_check_nline_tag_o;
    cmo_way_t   dir_check_nline_hit_way_i = '0;
    logic       dir_check_nline_dirty_i = 1'b0;
    logic       dir_check_entry_o;
    cmo_set_t   dir_check_entry_set_o;
    cmo_way_t   dir_check_entry_way_o;
    logic       dir_check_entry_valid_i = 1'b0;
    logic       dir_check_entry_dirty_i = 1'b0;
    cmo_tag_t   dir_check_entry_tag_i = '0;
    logic       dir_inval_o;
    cmo_set_t   dir_inval_set_o;
    cmo_way_t   dir_inval_way_o;
    logic       flush_alloc_o;
    logic       flush_alloc_ready_i;
    cmo_nline_t flush_alloc_nline_o;
    cmo_way_t   flush_alloc_way_o;

    // Directory contents per set and way
    logic       dir_valid [`CMO_SETS][`CMO_WAYS];
    logic       dir_dirty [`CMO_SETS][`CMO_WAYS];
    cmo_tag_t   dir_tag   [`CMO_SETS][`CMO_WAYS];
    logic       dir_filled = 1'b0;
    logic [1:0] fc_busy = '0;

    // Drain column is the buffer drain for fences and the flush-controller stall for flushes
    cmo_op_e    tbl_op    [ROWS];
    cmo_addr_t  tbl_addr  [ROWS];
    int         tbl_hold  [ROWS];
    int         tbl_drain [ROWS];

    int errors = 0;
    int checks = 0;
    int cur_row = -1;
    int cycle_cnt = 0;

    cmo_top u_dut (.*);

    always #20 clk_i = ~clk_i;

    task automatic expect_ok(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("CHECK FAILED at time %0t: row %0d: %s", $time, cur_row, what);
        end
    endtask

    function automatic cmo_addr_t line_addr(cmo_tag_t tag, cmo_set_t set);
        return {tag, set, `CMO_OFFSET_W'('h15)};
    endfunction

    function automatic cmo_way_t hit_mask(cmo_set_t set, cmo_tag_t tag);
        cmo_way_t m;
        m = '0;
        for (int w = 0; w < `CMO_WAYS; w++) begin
            m[w] = dir_valid[set][w] && (dir_tag[set][w] == tag);
        end
        return m;
    endfunction

    function automatic logic hit_dirty(cmo_set_t set, cmo_tag_t tag);
        logic d;
        d = 1'b0;
        for (int w = 0; w < `CMO_WAYS; w++) begin
            d = d | (dir_valid[set][w] && dir_tag[set][w] == tag && dir_dirty[set][w]);
        end
        return d;
    endfunction

    function automatic int way_index(cmo_way_t way);
        int idx;
        idx = 0;
        for (int w = 0; w < `CMO_WAYS; w++) begin
            if (way[w]) idx = w;
        end
        return idx;
    endfunction

    // Directory model that fills at random during reset and answers one cycle after each strobe
    always @(posedge clk_i) begin
        if (!rst_ni) begin
            if (!dir_filled) begin
                for (int s = 0; s < `CMO_SETS; s++) begin
                    for (int w = 0; w < `CMO_WAYS; w++) begin
                        dir_valid[s][w] <= (($urandom % 4) != 0);
                        dir_dirty[s][w] <= (($urandom % 2) == 1);
                        dir_tag[s][w]   <= {1'b0, RAND_TAG_W'($urandom)};
                    end
                end
                // Planted lines with reserved tags
                dir_valid[1][2] <= 1'b1;
                dir_dirty[1][2] <= 1'b1;
                dir_tag[1][2]   <= 23'h400055;
                dir_valid[2][1] <= 1'b1;
                dir_dirty[2][1] <= 1'b1;
                dir_tag[2][1]   <= 23'h400abc;
                dir_valid[5][3] <= 1'b1;
                dir_dirty[5][3] <= 1'b0;
                dir_tag[5][3]   <= 23'h400123;
                dir_valid[6][0] <= 1'b1;
                dir_dirty[6][0] <= 1'b1;
                dir_tag[6][0]   <= 23'h400777;
                dir_filled <= 1'b1;
            end
        end else begin
            if (dir_check_nline_o) begin
                dir_check_nline_hit_way_i <=
                    hit_mask(dir_check_nline_set_o, dir_check_nline_tag_o);
                dir_check_nline_dirty_i <=
                    hit_dirty(dir_check_nline_set_o, dir_check_nline_tag_o);
            end
            if (dir_check_entry_o) begin
                dir_check_entry_valid_i <=
                    dir_valid[dir_check_entry_set_o][way_index(dir_check_entry_way_o)];
                dir_check_entry_dirty_i <=
                    dir_dirty[dir_check_entry_set_o][way_index(dir_check_entry_way_o)];
                dir_check_entry_tag_i <=
                    dir_tag[dir_check_entry_set_o][way_index(dir_check_entry_way_o)];
            end
            if (dir_inval_o) begin
                for (int w = 0; w < `CMO_WAYS; w++) begin
                    if (dir_inval_way_o[w]) dir_valid[dir_inval_set_o][w] <= 1'b0;
                end
            end
        end
    end

    // Flush controller stays busy for two cycles after each accepted entry
    always @(posedge clk_i) begin
        if (flush_alloc_o && flush_alloc_ready_i) begin
            fc_busy       <= 2'd2;
            flush_empty_i <= 1'b0;
        end else if (fc_busy != 2'd0) begin
            fc_busy       <= fc_busy - 2'd1;
            flush_empty_i <= (fc_busy == 2'd1);
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("Errors found");
            $finish;
        end
    end

    task automatic set_row(input int idx, input cmo_op_e op, input cmo_addr_t addr,
                           input int hold, input int drain);
        tbl_op[idx]    = op;
        tbl_addr[idx]  = addr;
        tbl_hold[idx]  = hold;
        tbl_drain[idx] = drain;
    endtask

    // Status levels for interval n after the request is presented
    task automatic drive_status(input int n, input cmo_op_e op, input int hold,
                                input int drain, input logic is_flush);
        mshr_empty_i <= (n >= hold);
        if (op == CMO_FENCE) begin
            wbuf_empty_i <= (n >= drain);
            rtab_empty_i <= (n >= drain / 2);
        end
        if (is_flush && n < drain) begin
            flush_alloc_ready_i <= 1'b0;
        end else begin
            flush_alloc_ready_i <= (($urandom % 2) == 1);
        end
    endtask

    task automatic run_row(input int r);
        cmo_op_e    op;
        cmo_set_t   set;
        cmo_tag_t   tag;
        cmo_way_t   hit;
        int         hold, drain, start, end_n, n;
        int         probes, reads, invals, want_probes, want_reads, want_invals;
        logic       is_flush, done, prev_rok, prev_fempty;
        cmo_nline_t exp_nline_q[$];
        cmo_way_t   exp_way_q[$];
        cmo_nline_t pop_nline_q[$];
        cmo_way_t   pop_way_q[$];

        op       = tbl_op[r];
        set      = tbl_addr[r][`CMO_OFFSET_W +: `CMO_SET_W];
        tag      = tbl_addr[r][`CMO_OFFSET_W + `CMO_SET_W +: `CMO_TAG_W];
        hold     = tbl_hold[r];
        drain    = tbl_drain[r];
        start    = hold + 1;
        hit      = hit_mask(set, tag);
        is_flush = (op == CMO_FLUSH_ALL) || (op == CMO_FLUSH_NLINE);
        probes = 0;
        reads  = 0;
        invals = 0;
        want_probes = (op == CMO_INVAL_NLINE || op == CMO_FLUSH_NLINE) ? 1 : 0;
        want_reads  = (op == CMO_FLUSH_ALL) ? `CMO_SETS * `CMO_WAYS : 0;
        want_invals = (op == CMO_INVAL_ALL) ? `CMO_SETS :
                      (op == CMO_INVAL_NLINE && hit != '0) ? 1 : 0;
        case (op)
            CMO_FENCE:       end_n = drain + 1;
            CMO_INVAL_NLINE: end_n = start + 2;
            CMO_INVAL_ALL:   end_n = start + `CMO_SETS;
            default:         end_n = 0;
        endcase

        // Write-backs in set-major, way-minor order
        if (op == CMO_FLUSH_ALL) begin
            for (int s = 0; s < `CMO_SETS; s++) begin
                for (int w = 0; w < `CMO_WAYS; w++) begin
                    if (dir_valid[s][w] && dir_dirty[s][w]) begin
                        exp_nline_q.push_back({dir_tag[s][w], cmo_set_t'(s)});
                        exp_way_q.push_back(cmo_way_t'(1) << w);
                    end
                end
            end
        end
        if (op == CMO_FLUSH_NLINE && hit != '0 && hit_dirty(set, tag)) begin
            exp_nline_q.push_back({tag, set});
            exp_way_q.push_back(hit);
        end

        @(posedge clk_i);
        req_valid_i <= 1'b1;
        req_op_i    <= op;
        req_addr_i  <= tbl_addr[r];
        drive_status(0, op, hold, drain, is_flush);
        n = 0;
        done = 1'b0;
        prev_rok = 1'b0;
        prev_fempty = 1'b1;
        while (!done) begin
            @(negedge clk_i);
            // Entry reads walk the sets and ways in order
            if (dir_check_entry_o) begin
                expect_ok(dir_check_entry_set_o == cmo_set_t'(reads / `CMO_WAYS) &&
                          dir_check_entry_way_o == (cmo_way_t'(1) << (reads % `CMO_WAYS)),
                          "entry read out of set-major order");
            end
            probes += int'(dir_check_nline_o);
            reads  += int'(dir_check_entry_o);
            invals += int'(dir_inval_o);
            if (n == 0) expect_ok(req_ready_o, "handler not ready for the request");
            if (op == CMO_FENCE) begin
                expect_ok(wbuf_flush_all_o == (n <= drain && rtab_empty_i),
                          "write buffer drain request wrong");
                if (n >= 1) expect_ok(req_wait_o == (n <= drain), "fence wait flag wrong");
            end else begin
                expect_ok(!wbuf_flush_all_o, "write buffer drain outside a fence");
                if (n >= 1 && n < start) begin
                    expect_ok(req_wait_o && !req_ready_o, "hazard wait flag wrong");
                    expect_ok(!dir_check_nline_o && !dir_check_entry_o && !dir_inval_o,
                              "directory strobe during hazard wait");
                end
            end
            if (dir_check_nline_o) begin
                expect_ok(dir_check_nline_set_o == set && dir_check_nline_tag_o == tag,
                          "probe set or tag wrong");
            end
            if (op == CMO_INVAL_NLINE && n == start) begin
                expect_ok(dir_check_nline_o, "probe missing one cycle after start");
            end
            if (op == CMO_INVAL_NLINE && n == start + 1) begin
                expect_ok(dir_inval_o == (hit != '0), "line invalidation strobe wrong");
                if (hit != '0) begin
                    expect_ok(dir_inval_set_o == set && dir_inval_way_o == hit,
                              "line invalidation set or way wrong");
                end
            end
            if (op == CMO_INVAL_ALL && n >= start && n < start + `CMO_SETS) begin
                expect_ok(dir_inval_o && dir_inval_set_o == cmo_set_t'(n - start) &&
                          dir_inval_way_o == '1, "set invalidation missing or wrong");
            end
            if (flush_alloc_o && flush_alloc_ready_i) begin
                pop_nline_q.push_back(flush_alloc_nline_o);
                pop_way_q.push_back(flush_alloc_way_o);
            end
            if (end_n > 0 && n >= 1 && n < end_n) expect_ok(!req_ready_o, "idle too early");
            if (end_n > 0 && n == end_n) begin
                expect_ok(req_ready_o, "not idle at the end of the operation");
                done = 1'b1;
            end
            if (is_flush && n >= start && req_ready_o) begin
                expect_ok(!prev_rok && prev_fempty, "flush ended before the queue drained");
                done = 1'b1;
            end
            prev_rok    = flush_alloc_o;
            prev_fempty = flush_empty_i;
            if (!done) begin
                @(posedge clk_i);
                n++;
                req_valid_i <= 1'b0;
                drive_status(n, op, hold, drain, is_flush);
            end
        end

        expect_ok(probes == want_probes,
                  $sformatf("%0d probes, expected %0d", probes, want_probes));
        expect_ok(reads == want_reads,
                  $sformatf("%0d entry reads, expected %0d", reads, want_reads));
        expect_ok(invals == want_invals,
                  $sformatf("%0d invalidations, expected %0d", invals, want_invals));
        expect_ok(pop_nline_q.size() == exp_nline_q.size(),
                  $sformatf("%0d write-backs, expected %0d",
                            pop_nline_q.size(), exp_nline_q.size()));
        for (int i = 0; i < pop_nline_q.size() && i < exp_nline_q.size(); i++) begin
            expect_ok(pop_nline_q[i] == exp_nline_q[i] && pop_way_q[i] == exp_way_q[i],
                      $sformatf("write-back %0d line %h way %b, expected line %h way %b", i,
                                pop_nline_q[i], pop_way_q[i], exp_nline_q[i], exp_way_q[i]));
        end
    endtask

    initial begin
        void'($urandom(32'h68952044));
        rst_ni              = 1'b0;
        req_valid_i         = 1'b0;
        req_op_i            = CMO_FENCE;
        req_addr_i          = '0;
        wbuf_empty_i        = 1'b1;
        mshr_empty_i        = 1'b1;
        rtab_empty_i        = 1'b1;
        ctrl_empty_i        = 1'b1;
        flush_alloc_ready_i = 1'b0;

        set_row(0,  CMO_FENCE,       '0,                          0, 0);
        set_row(1,  CMO_FENCE,       '0,                          0, 5);
        set_row(2,  CMO_INVAL_NLINE, line_addr(23'h400055, 3'd1), 0, 0);
        set_row(3,  CMO_INVAL_NLINE, line_addr(23'h400999, 3'd3), 0, 0);
        set_row(4,  CMO_FLUSH_NLINE, line_addr(23'h400abc, 3'd2), 3, 2);
        set_row(5,  CMO_FLUSH_NLINE, line_addr(23'h400123, 3'd5), 0, 0);
        set_row(6,  CMO_FLUSH_ALL,   '0,                          0, 12);
        set_row(7,  CMO_FLUSH_NLINE, line_addr(23'h400777, 3'd6), 2, 0);
        set_row(8,  CMO_INVAL_ALL,   '0,                          4, 0);
        set_row(9,  CMO_FLUSH_ALL,   '0,                          0, 0);
        set_row(10, CMO_INVAL_NLINE, line_addr(23'h400abc, 3'd2), 1, 0);

        repeat (16) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        expect_ok(req_ready_o && !req_wait_o && !wbuf_flush_all_o, "request port after reset");
        expect_ok(!dir_check_nline_o && !dir_check_entry_o && !dir_inval_o && !flush_alloc_o,
                  "strobes after reset");

        for (int r = 0; r < ROWS; r++) begin
            cur_row = r;
            run_row(r);
        end

        $display("Summary: %0d rows, %0d checks, %0d errors", ROWS, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* logic/cmo_top.sv */
// Maintenance handler for a write-back cache; one operation in flight at a time
module cmo_top import cmo_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       req_valid_i,
    input  cmo_op_e    req_op_i,
    input  cmo_addr_t  req_addr_i,
    output logic       req_ready_o,
    output logic       req_wait_o,
    input  logic       wbuf_empty_i,
    input  logic       mshr_empty_i,
    input  logic       rtab_empty_i,
    input  logic       ctrl_empty_i,
    input  logic       flush_empty_i,
    output logic       wbuf_flush_all_o,
    output logic       dir_check_nline_o,
    output cmo_set_t   dir_check_nline_set_o,
    output cmo_tag_t   dir_check_nline_tag_o,
    input  cmo_way_t   dir_check_nline_hit_way_i,
    input  logic       dir_check_nline_dirty_i,
    output logic       dir_check_entry_o,
    output cmo_set_t   dir_check_entry_set_o,
    output cmo_way_t   dir_check_entry_way_o,
    input  logic       dir_check_entry_valid_i,
    input  logic       dir_check_entry_dirty_i,
    input  cmo_tag_t   dir_check_entry_tag_i,
    output logic       dir_inval_o,
    output cmo_set_t   dir_inval_set_o,
    output cmo_way_t   dir_inval_way_o,
    output logic       flush_alloc_o,
    input  logic       flush_alloc_ready_i,
    output cmo_nline_t flush_alloc_nline_o,
    output cmo_way_t   flush_alloc_way_o
);

    cmo_set_t walk_set;
    cmo_way_t walk_way;
    logic     walk_set_last;
    logic     walk_way_last;
    logic     walk_reset;
    logic     walk_step;
    logic     fifo_wok;
    logic     push;
    cmo_tag_t push_tag;
    cmo_set_t push_set;
    cmo_way_t push_way;

    cmo_ctrl u_ctrl (
        .clk_i,
        .rst_ni,
        .req_valid_i,
        .req_op_i,
        .req_addr_i,
        .req_ready_o,
        .req_wait_o,
        .wbuf_empty_i,
        .mshr_empty_i,
        .rtab_empty_i,
        .ctrl_empty_i,
        .flush_empty_i,
        .wbuf_flush_all_o,
        .dir_check_nline_o,
        .dir_check_nline_set_o,
        .dir_check_nline_tag_o,
        .dir_check_nline_hit_way_i,
        .dir_check_nline_dirty_i,
        .dir_check_entry_o,
        .dir_check_entry_set_o,
        .dir_check_entry_way_o,
        .dir_check_entry_valid_i,
        .dir_check_entry_dirty_i,
        .dir_check_entry_tag_i,
        .dir_inval_o,
        .dir_inval_set_o,
        .dir_inval_way_o,
        .walk_set_i      (walk_set),
        .walk_way_i      (walk_way),
        .walk_set_last_i (walk_set_last),
        .walk_way_last_i (walk_way_last),
        .walk_reset_o    (walk_reset),
        .walk_step_o     (walk_step),
        .fifo_wok_i      (fifo_wok),
        .fifo_rok_i      (flush_alloc_o),
        .push_o          (push),
        .push_tag_o      (push_tag),
        .push_set_o      (push_set),
        .push_way_o      (push_way)
    );

    cmo_walker u_walker (
        .clk_i,
        .rst_ni,
        .reset_i    (walk_reset),
        .step_i     (walk_step),
        .set_o      (walk_set),
        .way_o      (walk_way),
        .set_last_o (walk_set_last),
        .way_last_o (walk_way_last)
    );

    // Queue output is the flush controller request
    cmo_flush_fifo u_flush_fifo (
        .clk_i,
        .rst_ni,
        .push_i  (push),
        .tag_i   (push_tag),
        .set_i   (push_set),
        .way_i   (push_way),
        .pop_i   (flush_alloc_ready_i),
        .wok_o   (fifo_wok),
        .rok_o   (flush_alloc_o),
        .nline_o (flush_alloc_nline_o),
        .way_o   (flush_alloc_way_o)
    );

endmodule

/* logic/cmo_ctrl.sv */
// Handles one operation at a time; the requester must hold req_valid_i only while idle
// Directory results are expected one cycle after each probe or entry read
`include "cmo_defines.svh"

module cmo_ctrl import cmo_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       req_valid_i,
    input  cmo_op_e    req_op_i,
    input  cmo_addr_t  req_addr_i,
    output logic       req_ready_o,
    output logic       req_wait_o,
    input  logic       wbuf_empty_i,
    input  logic       mshr_empty_i,
    input  logic       rtab_empty_i,
    input  logic       ctrl_empty_i,
    input  logic       flush_empty_i,
    output logic       wbuf_flush_all_o,
    output logic       dir_check_nline_o,
    output cmo_set_t   dir_check_nline_set_o,
    output cmo_tag_t   dir_check_nline_tag_o,
    input  cmo_way_t   dir_check_nline_hit_way_i,
    input  logic       dir_check_nline_dirty_i,
    output logic       dir_check_entry_o,
    output cmo_set_t   dir_check_entry_set_o,
    output cmo_way_t   dir_check_entry_way_o,
    input  logic       dir_check_entry_valid_i,
    input  logic       dir_check_entry_dirty_i,
    input  cmo_tag_t   dir_check_entry_tag_i,
    output logic       dir_inval_o,
    output cmo_set_t   dir_inval_set_o,
    output cmo_way_t   dir_inval_way_o,
    input  cmo_set_t   walk_set_i,
    input  cmo_way_t   walk_way_i,
    input  logic       walk_set_last_i,
    input  logic       walk_way_last_i,
    output logic       walk_reset_o,
    output logic       walk_step_o,
    input  logic       fifo_wok_i,
    input  logic       fifo_rok_i,
    output logic       push_o,
    output cmo_tag_t   push_tag_o,
    output cmo_set_t   push_set_o,
    output cmo_way_t   push_way_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FENCE_WAIT,
        ST_HAZARD_WAIT,
        ST_LINE_PROBE,
        ST_SET_INVAL,
        ST_FLUSH_ALL,
        ST_FLUSH_LINE,
        ST_FLUSH_DRAIN
    } cmo_state_e;

    cmo_state_e state_q, state_d;
    cmo_op_e    op_q, op_d;
    cmo_addr_t  addr_q, addr_d;
    logic       pend_valid_q, pend_valid_d;
    cmo_set_t   pend_set_q, pend_set_d;
    cmo_way_t   pend_way_q, pend_way_d;
    cmo_set_t   line_set;
    cmo_tag_t   line_tag;
    logic       hazard_clear;
    logic       nline_hit;

    // First working state of each operation
    function automatic cmo_state_e start_state(cmo_op_e op);
        case (op)
            CMO_INVAL_NLINE: return ST_LINE_PROBE;
            CMO_INVAL_ALL:   return ST_SET_INVAL;
            CMO_FLUSH_NLINE: return ST_FLUSH_LINE;
            CMO_FLUSH_ALL:   return ST_FLUSH_ALL;
            default:         return ST_IDLE;
        endcase
    endfunction

    assign line_set     = addr_q[`CMO_OFFSET_W +: `CMO_SET_W];
    assign line_tag     = addr_q[`CMO_OFFSET_W + `CMO_SET_W +: `CMO_TAG_W];
    assign hazard_clear = mshr_empty_i & rtab_empty_i & ctrl_empty_i;
    assign nline_hit    = |dir_check_nline_hit_way_i;

    assign req_ready_o = (state_q == ST_IDLE);
    assign req_wait_o  = (state_q == ST_FENCE_WAIT) || (state_q == ST_HAZARD_WAIT);

    assign dir_check_nline_set_o = line_set;
    assign dir_check_nline_tag_o = line_tag;
    assign dir_check_entry_set_o = walk_set_i;
    assign dir_check_entry_way_o = walk_way_i;

    // Result of last cycle's probe or entry read goes to the write-back queue
    always_comb begin
        push_set_o = pend_set_q;
        if (op_q == CMO_FLUSH_NLINE) begin
            push_o     = pend_valid_q & nline_hit & dir_check_nline_dirty_i;
            push_tag_o = line_tag;
            push_way_o = dir_check_nline_hit_way_i;
        end else begin
            push_o     = pend_valid_q & dir_check_entry_valid_i & dir_check_entry_dirty_i;
            push_tag_o = dir_check_entry_tag_i;
            push_way_o = pend_way_q;
        end
    end

    always_comb begin
        state_d           = state_q;
        op_d              = op_q;
        addr_d            = addr_q;
        pend_valid_d      = 1'b0;
        pend_set_d        = pend_set_q;
        pend_way_d        = pend_way_q;
        wbuf_flush_all_o  = 1'b0;
        dir_check_nline_o = 1'b0;
        dir_check_entry_o = 1'b0;
        dir_inval_o       = 1'b0;
        dir_inval_set_o   = line_set;
        dir_inval_way_o   = dir_check_nline_hit_way_i;
        walk_reset_o      = 1'b0;
        walk_step_o       = 1'b0;

        unique case (state_q)
            ST_IDLE: begin
                if (req_valid_i) begin
                    op_d   = req_op_i;
                    addr_d = req_addr_i;
                    if (req_op_i == CMO_FENCE) begin
                        // Write buffer drain only once the replay table is quiet
                        wbuf_flush_all_o = rtab_empty_i;
                        if (!(wbuf_empty_i && rtab_empty_i)) begin
                            state_d = ST_FENCE_WAIT;
                        end
                    end else begin
                        walk_reset_o = 1'b1;
                        state_d = hazard_clear ? start_state(req_op_i) : ST_HAZARD_WAIT;
                    end
                end
            end
            ST_FENCE_WAIT: begin
                wbuf_flush_all_o = rtab_empty_i;
                if (wbuf_empty_i && rtab_empty_i) begin
                    state_d = ST_IDLE;
                end
            end
            ST_HAZARD_WAIT: begin
                if (hazard_clear) begin
                    state_d = start_state(op_q);
                end
            end
            ST_LINE_PROBE: begin
                dir_check_nline_o = 1'b1;
                state_d = ST_SET_INVAL;
            end
            ST_SET_INVAL: begin
                if (op_q == CMO_INVAL_NLINE) begin
                    dir_inval_o = nline_hit;
                    state_d = ST_IDLE;
                end else begin
                    // Rotor held at way 0 so every step moves to the next set
                    dir_inval_o     = 1'b1;
                    dir_inval_set_o = walk_set_i;
                    dir_inval_way_o = '1;
                    walk_reset_o    = 1'b1;
                    walk_step_o     = 1'b1;
                    if (walk_set_last_i) begin
                        state_d = ST_IDLE;
                    end
                end
            end
            ST_FLUSH_ALL: begin
                if (fifo_wok_i) begin
                    dir_check_entry_o = 1'b1;
                    walk_step_o  = 1'b1;
                    pend_valid_d = 1'b1;
                    pend_set_d   = walk_set_i;
                    pend_way_d   = walk_way_i;
                    if (walk_set_last_i && walk_way_last_i) begin
                        state_d = ST_FLUSH_DRAIN;
                    end
                end
            end
            ST_FLUSH_LINE: begin
                if (fifo_wok_i) begin
                    dir_check_nline_o = 1'b1;
                    pend_valid_d = 1'b1;
                    pend_set_d   = line_set;
                    state_d      = ST_FLUSH_DRAIN;
                end
            end
            ST_FLUSH_DRAIN: begin
                // Done once the queue and the flush controller are both empty
                if (!fifo_rok_i && flush_empty_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= ST_IDLE;
            pend_valid_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            pend_valid_q <= pend_valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        op_q       <= op_d;
        addr_q     <= addr_d;
        pend_set_q <= pend_set_d;
        pend_way_q <= pend_way_d;
    end

endmodule

/* logic/cmo_flush_fifo.sv */
// Feed-through queue; a push into an empty queue shows at the output in the same cycle
// wok_o counts this cycle's push and pop, so the writer may push once more next cycle
`include "cmo_defines.svh"

module cmo_flush_fifo import cmo_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       push_i,
    input  cmo_tag_t   tag_i,
    input  cmo_set_t   set_i,
    input  cmo_way_t   way_i,
    input  logic       pop_i,
    output logic       wok_o,
    output logic       rok_o,
    output cmo_nline_t nline_o,
    output cmo_way_t   way_o
);

    localparam int unsigned DEPTH = `CMO_FLUSH_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    cmo_nline_t         nline_mem [DEPTH];
    cmo_way_t           way_mem   [DEPTH];
    logic [PTR_W-1:0]   rptr_q, wptr_q;
    logic [CNT_W-1:0]   cnt_q, cnt_d;
    logic               empty;
    logic               wr;
    logic               rd;

    assign empty = (cnt_q == '0);
    // Push and pop on an empty queue bypass the storage
    assign wr    = push_i & ~(empty & pop_i);
    assign rd    = pop_i & ~empty;
    assign cnt_d = cnt_q + CNT_W'(wr) - CNT_W'(rd);

    assign wok_o   = (cnt_d != CNT_W'(DEPTH));
    assign rok_o   = ~empty | push_i;
    assign nline_o = empty ? {tag_i, set_i} : nline_mem[rptr_q];
    assign way_o   = empty ? way_i : way_mem[rptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rptr_q <= '0;
            wptr_q <= '0;
            cnt_q  <= '0;
        end else begin
            cnt_q <= cnt_d;
            if (wr) begin
                wptr_q <= (wptr_q == PTR_W'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
            end
            if (rd) begin
                rptr_q <= (rptr_q == PTR_W'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr) begin
            nline_mem[wptr_q] <= {tag_i, set_i};
            way_mem[wptr_q]   <= way_i;
        end
    end

endmodule

/* logic/cmo_walker.sv */
// Walks sets and ways in set-major order; reset_i with step_i moves the set and keeps way 0
`include "cmo_defines.svh"

module cmo_walker import cmo_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     reset_i,
    input  logic     step_i,
    output cmo_set_t set_o,
    output cmo_way_t way_o,
    output logic     set_last_o,
    output logic     way_last_o
);

    cmo_set_t set_q;
    cmo_way_t way_q;

    assign set_o      = set_q;
    assign way_o      = way_q;
    assign set_last_o = (set_q == cmo_set_t'(`CMO_SETS - 1));
    assign way_last_o = way_q[`CMO_WAYS-1];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            set_q <= '0;
            way_q <= cmo_way_t'(1);
        end else begin
            // One-hot rotor that wraps back to way 0
            if (reset_i) begin
                way_q <= cmo_way_t'(1);
            end else if (step_i) begin
                way_q <= {way_q[`CMO_WAYS-2:0], way_q[`CMO_WAYS-1]};
            end
            if (step_i && (reset_i || way_last_o)) begin
                set_q <= set_last_o ? '0 : set_q + 1'b1;
            end else if (reset_i) begin
                set_q <= '0;
            end
        end
    end

endmodule

/* logic/cmo_pkg.sv */
// Shared types for the maintenance handler; widths follow the geometry macros
`include "cmo_defines.svh"

package cmo_pkg;

    // One operation per request
    typedef enum logic [2:0] {
        CMO_FENCE       = 3'd0,
        CMO_INVAL_NLINE = 3'd1,
        CMO_INVAL_ALL   = 3'd2,
        CMO_FLUSH_NLINE = 3'd3,
        CMO_FLUSH_ALL   = 3'd4
    } cmo_op_e;

    typedef logic [`CMO_ADDR_W-1:0]  cmo_addr_t;
    typedef logic [`CMO_SET_W-1:0]   cmo_set_t;
    typedef logic [`CMO_TAG_W-1:0]   cmo_tag_t;
    typedef logic [`CMO_NLINE_W-1:0] cmo_nline_t;

    // One-hot way select
    typedef logic [`CMO_WAYS-1:0]    cmo_way_t;

endpackage

/* include/cmo_defines.svh */
// Cache geometry for the maintenance handler. The address split must add up to CMO_ADDR_W
// CMO_SETS and CMO_WAYS must agree with CMO_SET_W and the one-hot way vector width
`ifndef CMO_DEFINES_SVH
`define CMO_DEFINES_SVH

// Request address split
`define CMO_ADDR_W      32
`define CMO_OFFSET_W    6
`define CMO_SET_W       3
`define CMO_TAG_W       23

// Cache geometry
`define CMO_SETS        8
`define CMO_WAYS        4

// Line number is tag above set
`define CMO_NLINE_W     (`CMO_TAG_W + `CMO_SET_W)

`define CMO_FLUSH_DEPTH 3

`endif
